// ==== common/rsa_defs.svh ====
`ifndef RSA_DEFS_SVH
`define RSA_DEFS_SVH

// operand geometry
`define RSA_W       256
`define RSA_WORDS   8     // 32-bit words per operand

// wishbone word offsets, each block lsw first
`define RSA_ADDR_A     0  // cipher text y
`define RSA_ADDR_D     8  // private exponent
`define RSA_ADDR_N     16 // modulus
`define RSA_ADDR_X     24 // plain text, read only
`define RSA_ADDR_CTRL  32

// control word, write side
`define RSA_CTRL_START 0

// status word, read side
`define RSA_STAT_BUSY  0
`define RSA_STAT_DONE  1

`endif

// ==== common/rsa_pkg.sv ====
`include "rsa_defs.svh"

package rsa_pkg;

	typedef logic [`RSA_W-1:0] operand_t;
	typedef logic [`RSA_W+1:0] wide_t;    // two guard bits for montgomery sums
	typedef logic [31:0]       word_t;
	typedef logic [5:0]        addr_t;    // word address
	typedef logic [8:0]        bit_idx_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_PREP,
		SEQ_MONT,
		SEQ_CALC
	} seq_state_t;

	// operands handed from the bus registers to the core
	typedef struct packed {
		operand_t y;
		operand_t d;
		operand_t n;
	} rsa_job_t;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		addr_t adr;
		word_t dat;
	} wb_req_t;

endpackage

// ==== hdl/rsa_modulo_product.sv ====
`timescale 1ns/1ps
`include "rsa_defs.svh"

// y * 2^256 mod N by repeated doubling
module rsa_modulo_product (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start,
	input  rsa_pkg::operand_t i_n,
	input  rsa_pkg::operand_t i_y,
	output rsa_pkg::operand_t o_t,
	output logic              o_done
);

	rsa_pkg::operand_t acc;
	rsa_pkg::wide_t    dbl;  // 2*acc
	rsa_pkg::wide_t    dif;  // 2*acc - N, negative when msb set
	rsa_pkg::bit_idx_t cnt;
	logic              run;

	assign dbl = {1'b0, acc, 1'b0};
	assign dif = dbl - {2'b00, i_n};
	assign o_t = acc;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			run    <= 1'b0;
			cnt    <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				run <= 1'b1;
				cnt <= '0;
			end else if (run) begin
				cnt <= cnt + 1'b1;
				if (cnt == rsa_pkg::bit_idx_t'(`RSA_W - 1)) begin  // last doubling
					run    <= 1'b0;
					o_done <= 1'b1;
				end
			end
		end
	end

	// acc stays below N, so one subtract per step is enough
	always_ff @(posedge i_clk) begin
		if (i_start) begin
			acc <= i_y;
		end else if (run) begin
			acc <= dif[`RSA_W+1] ? dbl[`RSA_W-1:0] : dif[`RSA_W-1:0];
		end
	end

	a_no_restart: assert property (
		@(posedge i_clk) disable iff (i_rst) i_start |-> !run
	) else $error("modulo product started while running");

endmodule

// ==== hdl/rsa_montgomery.sv ====
`timescale 1ns/1ps
`include "rsa_defs.svh"

// bit-serial montgomery product, a*b*2^-256 mod N
module rsa_montgomery (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start,
	input  rsa_pkg::operand_t i_n,
	input  rsa_pkg::operand_t i_a,
	input  rsa_pkg::operand_t i_b,
	output rsa_pkg::operand_t o_m,
	output logic              o_done
);

	rsa_pkg::wide_t    sum;    // stays below 2N
	rsa_pkg::wide_t    add_b;
	rsa_pkg::wide_t    add_n;
	rsa_pkg::wide_t    dif;
	rsa_pkg::operand_t a_sh;   // a, lsb first
	rsa_pkg::bit_idx_t cnt;
	logic              run;
	logic              fin;    // final subtract cycle

	assign add_b = a_sh[0] ? sum + {2'b00, i_b} : sum;
	assign add_n = add_b[0] ? add_b + {2'b00, i_n} : add_b;  // make it even
	assign dif   = sum - {2'b00, i_n};

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			run    <= 1'b0;
			fin    <= 1'b0;
			cnt    <= '0;
			o_done <= 1'b0;
		end else begin
			fin    <= 1'b0;
			o_done <= fin;
			if (i_start) begin
				run <= 1'b1;
				cnt <= '0;
			end else if (run) begin
				cnt <= cnt + 1'b1;
				if (cnt == rsa_pkg::bit_idx_t'(`RSA_W - 1)) begin
					run <= 1'b0;
					fin <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start) begin
			sum  <= '0;
			a_sh <= i_a;
		end else if (run) begin
			sum  <= add_n >> 1;
			a_sh <= a_sh >> 1;
		end
		if (fin) begin
			o_m <= dif[`RSA_W+1] ? sum[`RSA_W-1:0] : dif[`RSA_W-1:0];
		end
	end

	a_no_restart: assert property (
		@(posedge i_clk) disable iff (i_rst) i_start |-> !(run || fin)
	) else $error("montgomery started while running");

	// result must be fully reduced against the held modulus
	a_reduced: assert property (
		@(posedge i_clk) disable iff (i_rst) o_done |-> (o_m < i_n)
	) else $error("montgomery result not below N");

endmodule

// ==== rsa_core/rsa_core.sv ====
`timescale 1ns/1ps
`include "rsa_defs.svh"

// right-to-left square-and-multiply, t in montgomery form and m in normal form
module rsa_core (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start,
	input  rsa_pkg::rsa_job_t i_job,
	output rsa_pkg::operand_t o_result,
	output logic              o_busy,
	output logic              o_done
);

	rsa_pkg::seq_state_t state;
	rsa_pkg::rsa_job_t   job;     // latched at start
	rsa_pkg::operand_t   t;       // y^(2^i) * R mod N
	rsa_pkg::operand_t   m;       // running product
	rsa_pkg::operand_t   prep_t;
	rsa_pkg::operand_t   mul_m;
	rsa_pkg::operand_t   sqr_m;
	rsa_pkg::operand_t   mul_r;
	rsa_pkg::operand_t   sqr_r;
	rsa_pkg::bit_idx_t   cnt;     // exponent bit
	logic                prep_go;
	logic                prep_done;
	logic                mont_go;
	logic                mul_done;
	logic                sqr_done;
	logic                mul_seen;
	logic                sqr_seen;
	logic                both_done;
	logic                d_bit;
	logic                last;

	// a done pulse may land in the same cycle or later than its partner
	assign both_done = (mul_seen | mul_done) & (sqr_seen | sqr_done);
	assign d_bit     = job.d[cnt[7:0]];
	assign last      = cnt == rsa_pkg::bit_idx_t'(`RSA_W - 1);
	assign o_busy    = state != rsa_pkg::SEQ_IDLE;

	rsa_modulo_product u_prep (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (prep_go),
		.i_n     (job.n),
		.i_y     (job.y),
		.o_t     (prep_t),
		.o_done  (prep_done)
	);

	rsa_montgomery u_mont_mul (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (mont_go),
		.i_n     (job.n),
		.i_a     (m),
		.i_b     (t),
		.o_m     (mul_m),
		.o_done  (mul_done)
	);

	rsa_montgomery u_mont_sqr (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (mont_go),
		.i_n     (job.n),
		.i_a     (t),
		.i_b     (t),
		.o_m     (sqr_m),
		.o_done  (sqr_done)
	);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state    <= rsa_pkg::SEQ_IDLE;
			prep_go  <= 1'b0;
			mont_go  <= 1'b0;
			mul_seen <= 1'b0;
			sqr_seen <= 1'b0;
			cnt      <= '0;
			o_done   <= 1'b0;
		end else begin
			prep_go <= 1'b0;
			mont_go <= 1'b0;
			o_done  <= 1'b0;
			if (mul_done) mul_seen <= 1'b1;
			if (sqr_done) sqr_seen <= 1'b1;
			case (state)
				rsa_pkg::SEQ_IDLE: begin
					if (i_start) begin
						state   <= rsa_pkg::SEQ_PREP;
						prep_go <= 1'b1;
					end
				end
				rsa_pkg::SEQ_PREP: begin
					if (prep_done) begin
						state   <= rsa_pkg::SEQ_MONT;
						mont_go <= 1'b1;
						cnt     <= '0;
					end
				end
				rsa_pkg::SEQ_MONT: begin
					if (both_done) state <= rsa_pkg::SEQ_CALC;
				end
				rsa_pkg::SEQ_CALC: begin
					mul_seen <= 1'b0;
					sqr_seen <= 1'b0;
					if (last) begin
						state  <= rsa_pkg::SEQ_IDLE;
						o_done <= 1'b1;
					end else begin
						state   <= rsa_pkg::SEQ_MONT;
						mont_go <= 1'b1;  // next round
						cnt     <= cnt + 1'b1;
					end
				end
				default: state <= rsa_pkg::SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (mul_done) mul_r <= mul_m;
		if (sqr_done) sqr_r <= sqr_m;
		case (state)
			rsa_pkg::SEQ_IDLE: begin
				if (i_start) job <= i_job;
			end
			rsa_pkg::SEQ_PREP: begin
				if (prep_done) begin
					t <= prep_t;
					m <= rsa_pkg::operand_t'(1);
				end
			end
			rsa_pkg::SEQ_CALC: begin
				t <= sqr_r;
				if (d_bit) m <= mul_r;
				if (last) o_result <= d_bit ? mul_r : m;
			end
			default: ;
		endcase
	end

	a_done_pulse: assert property (
		@(posedge i_clk) disable iff (i_rst) o_done |=> !o_done
	) else $error("core done held for two cycles");

endmodule

// ==== hdl/rsa_wb_regs.sv ====
`timescale 1ns/1ps
`include "rsa_defs.svh"

// wishbone classic slave holding the operand, result and control registers
module rsa_wb_regs (
	input  logic              i_clk,
	input  logic              i_rst,
	input  rsa_pkg::wb_req_t  i_wb,
	output rsa_pkg::word_t    o_wb_dat,
	output logic              o_wb_ack,
	input  logic              i_busy,
	input  logic              i_done,
	input  rsa_pkg::operand_t i_result,
	output rsa_pkg::rsa_job_t o_job,
	output logic              o_start
);

	rsa_pkg::rsa_job_t job;
	rsa_pkg::operand_t res;      // result readback
	rsa_pkg::word_t    rd_dat;
	rsa_pkg::addr_t    base;     // block base of the word address
	logic [7:0]        off;      // bit offset inside the block
	logic              ack;
	logic              done;     // sticky
	logic              req;
	logic              wr;
	logic              go;

	assign base     = i_wb.adr & ~rsa_pkg::addr_t'(`RSA_WORDS - 1);
	assign off      = {i_wb.adr[2:0], 5'd0};
	assign req      = i_wb.cyc & i_wb.stb & ~ack;  // first cycle of an access
	assign wr       = req & i_wb.we;
	assign go       = wr && (i_wb.adr == `RSA_ADDR_CTRL) && i_wb.dat[`RSA_CTRL_START]
	                  && !i_busy;
	assign o_wb_ack = ack;
	assign o_job    = job;

	always_comb begin
		rd_dat = '0;
		case (base)
			`RSA_ADDR_A: rd_dat = job.y[off +: $bits(rsa_pkg::word_t)];
			`RSA_ADDR_D: rd_dat = job.d[off +: $bits(rsa_pkg::word_t)];
			`RSA_ADDR_N: rd_dat = job.n[off +: $bits(rsa_pkg::word_t)];
			`RSA_ADDR_X: rd_dat = res[off +: $bits(rsa_pkg::word_t)];
			default: begin
				if (i_wb.adr == `RSA_ADDR_CTRL) begin
					rd_dat[`RSA_STAT_BUSY] = i_busy;
					rd_dat[`RSA_STAT_DONE] = done;
				end
			end
		endcase
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			ack     <= 1'b0;
			o_start <= 1'b0;
			done    <= 1'b0;
		end else begin
			ack     <= req;
			o_start <= go;
			if (i_done) done <= 1'b1;
			if (go) done <= 1'b0;  // new job
		end
	end

	always_ff @(posedge i_clk) begin
		if (req) o_wb_dat <= rd_dat;
		if (i_done) res <= i_result;
		// operands frozen while the engine runs
		if (wr && !i_busy) begin
			case (base)
				`RSA_ADDR_A: job.y[off +: $bits(rsa_pkg::word_t)] <= i_wb.dat;
				`RSA_ADDR_D: job.d[off +: $bits(rsa_pkg::word_t)] <= i_wb.dat;
				`RSA_ADDR_N: job.n[off +: $bits(rsa_pkg::word_t)] <= i_wb.dat;
				default: ;
			endcase
		end
	end

	a_ack_after_req: assert property (
		@(posedge i_clk) disable iff (i_rst) o_wb_ack |-> $past(i_wb.cyc && i_wb.stb)
	) else $error("wishbone ack without a request");

endmodule

// ==== hdl/rsa_top.sv ====
`timescale 1ns/1ps

module rsa_top (
	input  logic             i_clk,
	input  logic             i_rst,
	input  rsa_pkg::wb_req_t i_wb,
	output rsa_pkg::word_t   o_wb_dat,
	output logic             o_wb_ack
);

	rsa_pkg::rsa_job_t job;
	rsa_pkg::operand_t result;
	logic              start;
	logic              busy;
	logic              done;

	rsa_wb_regs u_regs (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_wb     (i_wb),
		.o_wb_dat (o_wb_dat),
		.o_wb_ack (o_wb_ack),
		.i_busy   (busy),
		.i_done   (done),
		.i_result (result),
		.o_job    (job),
		.o_start  (start)
	);

	rsa_core u_core (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (start),
		.i_job    (job),
		.o_result (result),
		.o_busy   (busy),
		.o_done   (done)
	);

endmodule

// ==== verification/rsa_tb_model.svh ====
`ifndef RSA_TB_MODEL_SVH
`define RSA_TB_MODEL_SVH

// a*b mod n, msb first shift and add, acc kept below n
task automatic mod_mul(input rsa_pkg::operand_t a, input rsa_pkg::operand_t b,
		input rsa_pkg::operand_t n, output rsa_pkg::operand_t r);
	logic [`RSA_W:0] acc;  // one spare bit for 2*acc and acc+a
	int              i;
	acc = '0;
	for (i = `RSA_W - 1; i >= 0; i--) begin
		acc = acc << 1;
		if (acc >= {1'b0, n}) acc = acc - {1'b0, n};
		if (b[i]) begin
			acc = acc + {1'b0, a};
			if (acc >= {1'b0, n}) acc = acc - {1'b0, n};
		end
	end
	r = acc[`RSA_W-1:0];
endtask

// y^d mod n, plain right-to-left square and multiply
task automatic mod_exp(input rsa_pkg::operand_t y, input rsa_pkg::operand_t d,
		input rsa_pkg::operand_t n, output rsa_pkg::operand_t r);
	rsa_pkg::operand_t acc;
	rsa_pkg::operand_t base;
	int                i;
	acc  = rsa_pkg::operand_t'(1);  // n > 1 always
	base = y;
	for (i = 0; i < `RSA_W; i++) begin
		if (d[i]) mod_mul(acc, base, n, acc);
		mod_mul(base, base, n, base);
	end
	r = acc;
endtask

task automatic check_operand(input string name, input rsa_pkg::operand_t expected,
		input rsa_pkg::operand_t actual);
	if (actual !== expected) begin
		$display("FAIL %s expected %h got %h", name, expected, actual);
		end_with_failure();
	end
endtask

task automatic check_word(input string name, input rsa_pkg::word_t expected,
		input rsa_pkg::word_t actual);
	if (actual !== expected) begin
		$display("FAIL %s expected %h got %h", name, expected, actual);
		end_with_failure();
	end
endtask

`endif

// ==== verification/rsa_tb.sv ====
`timescale 1ns/1ps
`include "rsa_defs.svh"

module rsa_tb;

	localparam int clk_period = 8;
	localparam int num_jobs   = 6;
	localparam int job_cycles = 80000;  // one job is about 67k cycles
	localparam int max_polls  = 40000;

	logic             clk;
	logic             rst;
	rsa_pkg::wb_req_t wb;
	rsa_pkg::word_t   wb_dat;
	logic             wb_ack;
	integer           seed;

	rsa_top UUT (
		.i_clk    (clk),
		.i_rst    (rst),
		.i_wb     (wb),
		.o_wb_dat (wb_dat),
		.o_wb_ack (wb_ack)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic end_with_failure();
		$display("Checks failed");
		$fatal(1);
	endtask

	`include "rsa_tb_model.svh"

	// one classic cycle with the request held until ack
	task automatic wb_access(input logic we, input rsa_pkg::addr_t adr,
			input rsa_pkg::word_t wdat, output rsa_pkg::word_t rdat);
		int waits;
		waits = 0;
		@(posedge clk);
		#1;
		if (wb_ack) begin
			$display("wishbone ack still high before the request to word %0d", adr);
			end_with_failure();
		end
		wb = {1'b1, 1'b1, we, adr, wdat};
		do begin
			@(posedge clk);
			#1;
			waits++;
			if (waits > 16) begin
				$display("no wishbone ack for word address %0d", adr);
				end_with_failure();
			end
		end while (!wb_ack);
		if (waits != 1) begin
			$display("wishbone ack for word %0d came %0d cycles late", adr, waits - 1);
			end_with_failure();
		end
		rdat = wb_dat;
		wb   = '0;
	endtask

	task automatic wb_write(input rsa_pkg::addr_t adr, input rsa_pkg::word_t dat);
		rsa_pkg::word_t unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input rsa_pkg::addr_t adr, output rsa_pkg::word_t dat);
		wb_access(1'b0, adr, '0, dat);
	endtask

	task automatic write_operand(input rsa_pkg::addr_t base, input rsa_pkg::operand_t v);
		for (int i = 0; i < `RSA_WORDS; i++) wb_write(base + i, v[32*i +: 32]);
	endtask

	task automatic read_operand(input rsa_pkg::addr_t base, output rsa_pkg::operand_t v);
		for (int i = 0; i < `RSA_WORDS; i++) wb_read(base + i, v[32*i +: 32]);
	endtask

	task automatic rand_operand(output rsa_pkg::operand_t v);
		for (int i = 0; i < `RSA_WORDS; i++) v[32*i +: 32] = $random(seed);
	endtask

	task automatic check_status(input logic busy, input logic done);
		rsa_pkg::word_t expected;
		rsa_pkg::word_t st;
		expected = '0;
		expected[`RSA_STAT_BUSY] = busy;
		expected[`RSA_STAT_DONE] = done;
		wb_read(`RSA_ADDR_CTRL, st);
		check_word("status", expected, st);
	endtask

	task automatic start_job(input rsa_pkg::operand_t y, input rsa_pkg::operand_t d,
			input rsa_pkg::operand_t n);
		write_operand(`RSA_ADDR_A, y);
		write_operand(`RSA_ADDR_D, d);
		write_operand(`RSA_ADDR_N, n);
		wb_write(`RSA_ADDR_CTRL, 32'h1 << `RSA_CTRL_START);
		check_status(1'b1, 1'b0);  // old done must be gone
	endtask

	task automatic finish_job(input rsa_pkg::operand_t y, input rsa_pkg::operand_t d,
			input rsa_pkg::operand_t n, output rsa_pkg::operand_t got);
		rsa_pkg::operand_t expected;
		rsa_pkg::word_t    st;
		int                polls;
		polls = 0;
		st    = '0;
		while (!st[`RSA_STAT_DONE]) begin
			wb_read(`RSA_ADDR_CTRL, st);
			polls++;
			if (polls > max_polls) begin
				$display("decryption did not finish within %0d status polls", max_polls);
				end_with_failure();
			end
		end
		check_status(1'b0, 1'b1);
		read_operand(`RSA_ADDR_X, got);
		mod_exp(y, d, n, expected);
		check_operand("plain text", expected, got);
	endtask

	task automatic rand_key(output rsa_pkg::operand_t y, output rsa_pkg::operand_t n);
		rand_operand(n);
		rand_operand(y);
		n[0]        = 1'b1;  // odd modulus
		n[`RSA_W-1] = 1'b1;
		y[`RSA_W-1] = 1'b0;  // so y < n
	endtask

	task automatic test_reset();
		rsa_pkg::word_t w;
		check_status(1'b0, 1'b0);
		wb_read(6'd40, w);
		check_word("unmapped read", '0, w);
		wb_read(6'd33, w);
		check_word("unmapped read", '0, w);
	endtask

	task automatic test_readback();
		rsa_pkg::operand_t y, d, n, v;
		rand_operand(y);
		rand_operand(d);
		rand_operand(n);
		write_operand(`RSA_ADDR_A, y);
		write_operand(`RSA_ADDR_D, d);
		write_operand(`RSA_ADDR_N, n);
		read_operand(`RSA_ADDR_A, v);
		check_operand("readback y", y, v);
		read_operand(`RSA_ADDR_D, v);
		check_operand("readback d", d, v);
		read_operand(`RSA_ADDR_N, v);
		check_operand("readback n", n, v);
	endtask

	task automatic test_known();
		rsa_pkg::operand_t y, n, got;
		rand_key(y, n);
		start_job(y, 256'd1, n);
		finish_job(y, 256'd1, n, got);
		check_operand("d=1 result", y, got);
		start_job(y, 256'd0, n);  // second start clears done and replaces the result
		finish_job(y, 256'd0, n, got);
		check_operand("d=0 result", 256'd1, got);
		start_job(256'd4, 256'd13, 256'd497);
		finish_job(256'd4, 256'd13, 256'd497, got);
		check_operand("4^13 mod 497", 256'd445, got);
	endtask

	task automatic test_random();
		rsa_pkg::operand_t y, d, n, got;
		for (int k = 0; k < 2; k++) begin
			rand_key(y, n);
			rand_operand(d);
			start_job(y, d, n);
			finish_job(y, d, n, got);
		end
	endtask

	// third random case with operand writes while the core runs
	task automatic test_busy_write();
		rsa_pkg::operand_t y, d, n, got;
		rsa_pkg::word_t    w;
		rand_key(y, n);
		rand_operand(d);
		start_job(y, d, n);
		wb_write(`RSA_ADDR_A, ~y[31:0]);
		wb_write(`RSA_ADDR_N + 7, 32'h0);
		check_status(1'b1, 1'b0);
		wb_read(`RSA_ADDR_A, w);
		check_word("y word 0 after busy write", y[31:0], w);
		wb_read(`RSA_ADDR_N + 7, w);
		check_word("n word 7 after busy write", n[255:224], w);
		finish_job(y, d, n, got);
	endtask

	initial begin
		seed = 32'hd2e4_259f;
		clk  = 1'b0;
		rst  = 1'b1;
		wb   = '0;
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;
		test_reset();
		test_readback();
		test_known();
		test_random();
		test_busy_write();
		$display("All checks passed");
		$finish;
	end

	initial begin : watchdog
		#(num_jobs * job_cycles * clk_period);
		$display("watchdog expired, the run took longer than %0d jobs", num_jobs);
		end_with_failure();
	end

endmodule

// ==== tb.f ====
+incdir+common
+incdir+verification
common/rsa_pkg.sv
hdl/rsa_modulo_product.sv
hdl/rsa_montgomery.sv
rsa_core/rsa_core.sv
hdl/rsa_wb_regs.sv
hdl/rsa_top.sv
verification/rsa_tb.sv
